// ==== irdSubsystem.f ====
+incdir+.
irdPkg.sv
irdDecodeIf.sv
prefetchQueue.sv
tStateSequencer.sv
irdDecode.sv
decodeStage.sv
irdSubsystem.sv
tbIrdSubsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tbIrdSubsystem
FILELIST = irdSubsystem.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== irdRefModel.svh ====
`ifndef IRD_REF_MODEL_SVH
`define IRD_REF_MODEL_SVH

// Expected controls for one opcode word
typedef struct packed {
	logic [15:0] opcode;
	logic [2:0] rx;
	logic [2:0] ry;
	logic rxIsAreg;
	logic ryIsAreg;
	logic rxIsDt;
	logic ryIsDt;
	logic rxIsUsp;
	logic rxIsMovem;
	logic movemPreDecr;
	logic implicitSp;
	logic isByte;
	logic isPcRel;
	logic isTas;
	logic isMovep;
	logic toCcr;
	logic inhibitCcr;
	logic [irdPkg::FTU_WIDTH-1:0] ftuConst;
	logic [irdPkg::TVN_WIDTH-1:0] macroTvn;
} irdExpect;

function automatic irdExpect irdRefDecode(input logic [15:0] op);
	irdExpect e;
	logic [3:0] ln;
	logic [1:0] sz;
	logic [2:0] mode;
	logic regShift;
	logic eaAreg;
	ln = op[15:12];
	sz = op[7:6];
	mode = op[5:3];
	regShift = (ln == 4'hE) && (sz != 2'b11);
	eaAreg = (mode != 3'b000) && (mode != 3'b111);
	e = '0;
	e.opcode = op;
	e.rx = op[11:9];
	e.ry = op[2:0];
	e.isTas = (ln == 4'h4) && (op[11:6] == 6'b101011);
	e.isPcRel = (mode == 3'b111) && !op[2] && op[1] && !(regShift && op[5]);
	e.implicitSp = ((ln == 4'h6) && (op[11:8] == 4'h1))
		|| ((ln == 4'h4) && ((op[11:8] == 4'hE) || (op[11:6] == 6'b100001)));
	case (ln)
		4'h1, 4'h2, 4'h3: e.rxIsAreg = (op[8:6] != 3'b000);
		4'h4: e.rxIsAreg = (op[8:6] == 3'b111);
		4'h8, 4'hC: e.rxIsAreg = (mode == 3'b001) && op[8] && !op[7];
		4'h9, 4'hB, 4'hD: e.rxIsAreg = (sz == 2'b11) || ((mode == 3'b001) && op[8]);
		default: e.rxIsAreg = e.implicitSp;
	endcase
	e.rxIsMovem = (ln == 4'h4) && !op[8] && !e.implicitSp;
	e.movemPreDecr = e.rxIsMovem && (mode == 3'b100);
	e.rxIsDt = (ln == 4'h5) || ((ln == 4'h0) && !op[8]);
	e.rxIsUsp = (ln == 4'h4) && (op[11:4] == 8'hE6);
	e.ryIsDt = (mode == 3'b111) && !op[1] && !regShift;
	case (ln)
		4'h5: e.ryIsAreg = eaAreg && (op[7:3] != 5'b11001);
		4'h6, 4'h7: e.ryIsAreg = 1'b0;
		4'hE: e.ryIsAreg = !regShift;
		default: e.ryIsAreg = eaAreg;
	endcase
	case (ln)
		4'h0: e.isByte = (op[8] && (op[5:4] != 2'b00))
			|| ((op[11:8] == 4'h8) && (op[5:4] != 2'b00))
			|| ((op[8:7] == 2'b10) && (mode == 3'b001))
			|| ((op[8:6] == 3'b000) && !((op[11:8] == 4'h8) && (op[5:4] == 2'b00)));
		4'h1: e.isByte = 1'b1;
		4'h4: e.isByte = (sz == 2'b00) || e.isTas;
		4'h5: e.isByte = (sz == 2'b00) || ((sz == 2'b11) && (mode != 3'b001));
		4'h8, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE: e.isByte = (sz == 2'b00);
		default: e.isByte = 1'b0;
	endcase
	e.isMovep = (ln == 4'h0) && op[8] && (mode == 3'b001);
	e.toCcr = ((ln == 4'h4) && ((op[11:0] == 12'hE77) || (op[11:6] == 6'b010011)))
		|| ((ln == 4'h0) && (op[8:6] == 3'b000));
	case (ln)
		4'h6, 4'h7: e.ftuConst = {{8{op[7]}}, op[7:0]};
		4'h5, 4'hE: e.ftuConst = (op[11:9] == 3'd0) ? 16'd8 : {13'd0, op[11:9]};
		4'h8, 4'hC: e.ftuConst = 16'h000F;
		4'h4: e.ftuConst = 16'h0080;
		default: e.ftuConst = 16'h0000;
	endcase
	if (ln != 4'h4)
		e.macroTvn = irdPkg::TVN_DIVZERO;
	else if (op[6:5] == 2'b11)
		e.macroTvn = irdPkg::TVN_TRAPV;
	else if (op[6:5] == 2'b10)
		e.macroTvn = irdPkg::TVN_TRAP_BASE + {4'b0000, op[3:0]};
	else
		e.macroTvn = irdPkg::TVN_CHK;
	e.inhibitCcr = (((ln == 4'h9) || (ln == 4'hD)) && (sz == 2'b11))
		|| ((ln == 4'h5) && (mode == 3'b001))
		|| (((ln == 4'h2) || (ln == 4'h3)) && (op[8:6] == 3'b001));
	return e;
endfunction

`endif

// ==== tbIrdSubsystem.sv ====
`timescale 1ns/1ps

module tbIrdSubsystem;
	`include "irdRefModel.svh"

	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_DIRECTED = 40;
	localparam int NUM_RANDOM = 300;

	logic clk = 1'b0;
	logic reset;
	logic wordValid;
	logic [15:0] opcodeWord;
	logic creditReturn;
	logic decodedValid;
	logic [2:0] rx;
	logic [2:0] ry;
	logic rxIsAreg;
	logic ryIsAreg;
	logic rxIsDt;
	logic ryIsDt;
	logic rxIsUsp;
	logic rxIsMovem;
	logic movemPreDecr;
	logic implicitSp;
	logic isByte;
	logic isPcRel;
	logic isTas;
	logic isMovep;
	logic toCcr;
	logic inhibitCcr;
	logic [irdPkg::FTU_WIDTH-1:0] ftuConst;
	logic [irdPkg::TVN_WIDTH-1:0] macroTvn;

	irdExpect expQ [$]; // Sent words in send order
	int validAt [$]; // Cycle of each decodedValid
	int credits;
	int sentCount = 0;
	int returnCount = 0;
	int errors = 0;
	int mismatches = 0;
	int cycle = 0;
	int cycleLimit = 8 * (NUM_DIRECTED + NUM_RANDOM + QUEUE_DEPTH) + 200;
	integer seed = 84;

	// One or more per line including the awkward corners
	logic [15:0] directedOps [NUM_DIRECTED] = '{
		16'h0000, 16'h003C, 16'h0108, 16'h01D0, 16'h0800, // ORI, ORI CCR, MOVEP, BSET, BTST
		16'h1200, 16'h2040, 16'h3010, // MOVE.B, MOVEA.L, MOVE.W
		16'h4E45, 16'h4E76, 16'h4AC0, 16'h48E7, 16'h4E75, // TRAP #5, TRAPV, TAS, MOVEM -(A7), RTS
		16'h44C0, 16'h4181, 16'h41FA, 16'h4E68, 16'h4850, 16'h4E77, // MOVE CCR .. RTR
		16'h5080, 16'h5349, 16'h51C8, 16'h50C0, // ADDQ #8, SUBQ An, DBF, ST
		16'h61FE, 16'h60FE, 16'h70FF, // BSR.S, BRA.S, MOVEQ #-1
		16'h8000, 16'h80C1, 16'h8109, 16'h9240, 16'h91C8, // OR.B, DIVU, SBCD, SUB, SUBA
		16'hA000, 16'hB348, 16'hC0C1, 16'hC149, 16'hD0C8, // Line A, CMPM, MULU, EXG, ADDA
		16'hE1A0, 16'hE1D0, 16'hE048, 16'hF000 // Dynamic, memory and static shifts, line F
	};

	irdSubsystem #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) UUT (
		.*
	);

	always #10 clk = ~clk; // 20 ns period

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			$display("timeout: not all words decoded, %0d still outstanding", expQ.size());
			$display("Errors: %0d, mismatches: %0d", errors, mismatches);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic checkField(input string name, input logic [15:0] got,
			input logic [15:0] want, input logic [15:0] op);
		assert (got === want) else begin
			mismatches++;
			$display("Error at %0t ns: opcode %h field %s got %h expected %h",
				$time, op, name, got, want);
		end
	endtask

	task automatic compareResult(input irdExpect e);
		checkField("rx", 16'(rx), 16'(e.rx), e.opcode);
		checkField("ry", 16'(ry), 16'(e.ry), e.opcode);
		checkField("rxIsAreg", 16'(rxIsAreg), 16'(e.rxIsAreg), e.opcode);
		checkField("ryIsAreg", 16'(ryIsAreg), 16'(e.ryIsAreg), e.opcode);
		checkField("rxIsDt", 16'(rxIsDt), 16'(e.rxIsDt), e.opcode);
		checkField("ryIsDt", 16'(ryIsDt), 16'(e.ryIsDt), e.opcode);
		checkField("rxIsUsp", 16'(rxIsUsp), 16'(e.rxIsUsp), e.opcode);
		checkField("rxIsMovem", 16'(rxIsMovem), 16'(e.rxIsMovem), e.opcode);
		checkField("movemPreDecr", 16'(movemPreDecr), 16'(e.movemPreDecr), e.opcode);
		checkField("implicitSp", 16'(implicitSp), 16'(e.implicitSp), e.opcode);
		checkField("isByte", 16'(isByte), 16'(e.isByte), e.opcode);
		checkField("isPcRel", 16'(isPcRel), 16'(e.isPcRel), e.opcode);
		checkField("isTas", 16'(isTas), 16'(e.isTas), e.opcode);
		checkField("isMovep", 16'(isMovep), 16'(e.isMovep), e.opcode);
		checkField("toCcr", 16'(toCcr), 16'(e.toCcr), e.opcode);
		checkField("inhibitCcr", 16'(inhibitCcr), 16'(e.inhibitCcr), e.opcode);
		checkField("ftuConst", ftuConst, e.ftuConst, e.opcode);
		checkField("macroTvn", 16'(macroTvn), 16'(e.macroTvn), e.opcode);
	endtask

	// Outputs sampled mid-cycle away from the rising edge
	always @(negedge clk) begin
		if (!reset) begin
			if (sentCount == 0) begin
				assert (!creditReturn && !decodedValid) else begin
					errors++;
					$display("Output pulse at %0t ns before any word was sent", $time);
				end
			end
			if (decodedValid) begin
				validAt.push_back(cycle);
				if (expQ.size() == 0) begin
					errors++;
					$display("decodedValid at %0t ns with no word outstanding", $time);
				end else begin
					compareResult(expQ.pop_front());
				end
			end
		end
	end

	// Credit back from the queue
	task automatic absorbCredit();
		if (creditReturn) begin
			credits++;
			returnCount++;
			assert (credits <= QUEUE_DEPTH) else begin
				errors++;
				$display("Credit count went above the queue depth at %0t ns", $time);
			end
		end
	endtask

	task automatic idleCycles(input int n);
		wordValid = 1'b0;
		repeat (n) begin
			@(negedge clk);
			absorbCredit();
		end
	endtask

	// Waits for a credit, then drives one word for one cycle
	task automatic pushWord(input logic [15:0] op);
		while (credits == 0) begin
			wordValid = 1'b0;
			@(negedge clk);
			absorbCredit();
		end
		wordValid = 1'b1;
		opcodeWord = op;
		credits--;
		sentCount++;
		expQ.push_back(irdRefDecode(op));
		@(negedge clk);
		absorbCredit();
	endtask

	task automatic waitDrain();
		wordValid = 1'b0;
		while (expQ.size() != 0) begin
			idleCycles(1);
		end
		idleCycles(4); // Last credit pulse lands before this
	endtask

	initial begin
		int r;
		int gap;
		int pushCycle;
		int firstIdx;
		reset = 1'b1;
		wordValid = 1'b0;
		opcodeWord = '0;
		credits = QUEUE_DEPTH;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idleCycles(6); // Quiet outputs checked by the monitor

		foreach (directedOps[i]) begin
			pushWord(directedOps[i]);
			idleCycles(i % 3); // Mix of gaps and back-to-back
		end
		waitDrain();

		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = $random(seed);
			pushWord(r[15:0]);
			r = $random(seed);
			gap = r & 7;
			if (gap >= 4) gap = 0; // Favour bursts so credits run dry
			idleCycles(gap);
		end
		waitDrain();

		// Idle empty queue, then a full-credit burst
		pushCycle = cycle + 1; // Edge that takes the first word
		firstIdx = validAt.size();
		repeat (QUEUE_DEPTH) begin
			r = $random(seed);
			pushWord(r[15:0]);
		end
		waitDrain();
		assert (validAt[firstIdx] - pushCycle == 4) else begin
			errors++;
			$display("Error at %0t ns: first result %0d cycles after push, expected 4",
				$time, validAt[firstIdx] - pushCycle);
		end
		for (int i = 1; i < QUEUE_DEPTH; i++) begin
			assert (validAt[firstIdx + i] - validAt[firstIdx + i - 1] == 4) else begin
				errors++;
				$display("Error at %0t ns: results %0d cycles apart in burst, expected 4",
					$time, validAt[firstIdx + i] - validAt[firstIdx + i - 1]);
			end
		end

		assert (returnCount == sentCount && credits == QUEUE_DEPTH) else begin
			errors++;
			$display("Credits lost: %0d sent, %0d returned, %0d held",
				sentCount, returnCount, credits);
		end

		$display("Errors: %0d, mismatches: %0d", errors, mismatches);
		if (errors == 0 && mismatches == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end
endmodule

// ==== irdSubsystem.sv ====
`timescale 1ns/1ps

module irdSubsystem #(
	parameter int QUEUE_DEPTH = 4 // Also the initial credit count
) (
	input logic clk,
	input logic reset,
	input logic wordValid,
	input logic [irdPkg::OPCODE_WIDTH-1:0] opcodeWord,
	output logic creditReturn,
	output logic decodedValid,
	output logic [2:0] rx,
	output logic [2:0] ry,
	output logic rxIsAreg,
	output logic ryIsAreg,
	output logic rxIsDt,
	output logic ryIsDt,
	output logic rxIsUsp,
	output logic rxIsMovem,
	output logic movemPreDecr,
	output logic implicitSp,
	output logic isByte,
	output logic isPcRel,
	output logic isTas,
	output logic isMovep,
	output logic toCcr,
	output logic inhibitCcr,
	output logic [irdPkg::FTU_WIDTH-1:0] ftuConst,
	output logic [irdPkg::TVN_WIDTH-1:0] macroTvn
);
	irdPkg::opcodeWord headWord; // Queue head, valid with wordAvail
	irdPkg::opcodeWord ird;
	logic wordAvail;
	logic pop;
	logic [3:0] tPhase;

	irdDecodeIf decBus ();

	prefetchQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue (
		.clk(clk),
		.reset(reset),
		.wordValid(wordValid),
		.wordIn(opcodeWord),
		.pop(pop),
		.headWord(headWord),
		.wordAvail(wordAvail),
		.creditReturn(creditReturn)
	);

	tStateSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.wordAvail(wordAvail),
		.tPhase(tPhase),
		.pop(pop)
	);

	// Registered outputs map one to one onto the top ports
	decodeStage stage (
		.dec(decBus),
		.*
	);

	irdDecode decoder (
		.ird(ird),
		.dec(decBus)
	);
endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic reset,
	input logic [3:0] tPhase,
	input irdPkg::opcodeWord headWord,
	output irdPkg::opcodeWord ird,
	irdDecodeIf.stage dec,
	output logic decodedValid,
	output logic [2:0] rx,
	output logic [2:0] ry,
	output logic rxIsAreg,
	output logic ryIsAreg,
	output logic rxIsDt,
	output logic ryIsDt,
	output logic rxIsUsp,
	output logic rxIsMovem,
	output logic movemPreDecr,
	output logic implicitSp,
	output logic isByte,
	output logic isPcRel,
	output logic isTas,
	output logic isMovep,
	output logic toCcr,
	output logic inhibitCcr,
	output logic [irdPkg::FTU_WIDTH-1:0] ftuConst,
	output logic [irdPkg::TVN_WIDTH-1:0] macroTvn
);
	always_ff @(posedge clk) begin
		if (tPhase[0]) begin
			ird <= headWord; // IRD load, same edge as the pop
		end
		if (tPhase[1]) begin
			ftuConst <= dec.ftuConst; // FTU wants it before T3
		end
		if (tPhase[2]) begin
			rx <= dec.rx;
			ry <= dec.ry;
			rxIsAreg <= dec.rxIsAreg;
			ryIsAreg <= dec.ryIsAreg;
			rxIsDt <= dec.rxIsDt;
			ryIsDt <= dec.ryIsDt;
			rxIsUsp <= dec.rxIsUsp;
			rxIsMovem <= dec.rxIsMovem;
			movemPreDecr <= dec.movemPreDecr;
			implicitSp <= dec.implicitSp;
			isByte <= dec.isByte;
			isPcRel <= dec.isPcRel;
			isTas <= dec.isTas;
			isMovep <= dec.isMovep;
			toCcr <= dec.toCcr;
			inhibitCcr <= dec.inhibitCcr;
			macroTvn <= dec.macroTvn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			decodedValid <= 1'b0;
		end else begin
			decodedValid <= tPhase[2]; // High during T4 only
		end
	end

	// Controls latched on T2 and T3 must come from the word loaded on T1
	assert property (@(posedge clk) disable iff (reset) (tPhase[2] | tPhase[3]) |-> $stable(ird))
		else $error("decodeStage: IRD changed inside an instruction");
endmodule

// ==== irdDecode.sv ====
`timescale 1ns/1ps

module irdDecode (
	input irdPkg::opcodeWord ird,
	irdDecodeIf.decoder dec
);
	logic [3:0] line;
	logic [2:0] opmode;
	logic [2:0] eaMode;
	logic [1:0] size;
	logic [3:0] cond;
	logic [7:0] disp8;
	logic [15:0] lineOneHot;
	logic isRegShift;
	logic isDynShift;
	logic eaIsAn;
	logic sizeIs11;
	logic isScc;
	logic staticOnReg;
	logic implicitSp;
	logic isTas;
	logic rxIsMovem;
	logic eaIsAreg;
	logic [3:0] quick; // ADDQ/SUBQ and shift count
	logic [irdPkg::FTU_WIDTH-1:0] ftuConst;

	assign line = ird.generalView.line;
	assign opmode = ird.generalView.opmode;
	assign eaMode = ird.generalView.eaMode;
	assign size = opmode[1:0]; // Bits 7-6
	assign cond = ird.branchView.cond;
	assign disp8 = ird.branchView.disp8;
	assign lineOneHot = 16'b1 << line;

	assign isRegShift = lineOneHot[14] & (size != 2'b11); // Memory shifts use size 11
	assign isDynShift = isRegShift & ird[5]; // Count in a register
	assign eaIsAn = (eaMode == 3'b001);
	assign sizeIs11 = (size == 2'b11);
	assign isScc = sizeIs11 & ~eaIsAn; // Size 11 on line 5 and not DBcc
	assign staticOnReg = (cond == 4'b1000) & (ird[5:4] == 2'b00);

	assign dec.rx = ird.generalView.rx;
	assign dec.ry = ird.generalView.eaReg;

	assign isTas = lineOneHot[4] & (ird[11:6] == 6'b101011);
	assign dec.isTas = isTas;
	assign dec.isPcRel = (&eaMode) & ~ird[2] & ird[1] & ~isDynShift; // d16(PC), d8(PC,Xn)

	always_comb begin
		unique case (1'b1)
			lineOneHot[6]: implicitSp = (cond == 4'b0001); // BSR
			lineOneHot[4]: implicitSp = (cond == 4'b1110) | (ird[11:6] == 6'b100001); // JSR/RTS, PEA
			default: implicitSp = 1'b0;
		endcase
	end
	assign dec.implicitSp = implicitSp;

	always_comb begin
		unique case (1'b1)
			lineOneHot[1], lineOneHot[2], lineOneHot[3]:
				dec.rxIsAreg = |opmode; // MOVE destination other than Dn
			lineOneHot[4]: dec.rxIsAreg = &opmode; // LEA
			lineOneHot[8], lineOneHot[12]:
				dec.rxIsAreg = eaIsAn & ird[8] & ~ird[7]; // SBCD, ABCD, EXG
			lineOneHot[9], lineOneHot[11], lineOneHot[13]:
				dec.rxIsAreg = sizeIs11 | (eaIsAn & ird[8] & ~sizeIs11); // xxxA, xxxX, CMPM
			default: dec.rxIsAreg = implicitSp;
		endcase
	end

	assign rxIsMovem = lineOneHot[4] & ~ird[8] & ~implicitSp;
	assign dec.rxIsMovem = rxIsMovem;
	assign dec.movemPreDecr = rxIsMovem & (eaMode == 3'b100);
	assign dec.rxIsDt = lineOneHot[5] | (lineOneHot[0] & ~ird[8]); // Quick and immediate data
	assign dec.rxIsUsp = lineOneHot[4] & (ird[11:4] == 8'hE6); // MOVE USP
	assign dec.ryIsDt = (eaMode == 3'b111) & ~ird[1] & ~isRegShift; // Absolute or immediate

	assign eaIsAreg = (eaMode != 3'b000) & (eaMode != 3'b111);

	always_comb begin
		unique case (1'b1)
			lineOneHot[5]: dec.ryIsAreg = eaIsAreg & (ird[7:3] != 5'b11001); // Not DBcc
			lineOneHot[6], lineOneHot[7]: dec.ryIsAreg = 1'b0; // No EA field
			lineOneHot[14]: dec.ryIsAreg = ~isRegShift;
			default: dec.ryIsAreg = eaIsAreg;
		endcase
	end

	always_comb begin
		unique case (1'b1)
			lineOneHot[0]:
				dec.isByte = (ird[8] & (ird[5:4] != 2'b00)) // Dynamic bit op on memory
					| ((cond == 4'b1000) & (ird[5:4] != 2'b00)) // Static bit op on memory
					| ((ird[8:7] == 2'b10) & eaIsAn) // MOVEP read
					| ((opmode == 3'b000) & ~staticOnReg); // Immediate .B
			lineOneHot[1]: dec.isByte = 1'b1; // MOVE.B
			lineOneHot[4]: dec.isByte = (size == 2'b00) | isTas;
			lineOneHot[5]: dec.isByte = (size == 2'b00) | isScc;
			lineOneHot[8], lineOneHot[9], lineOneHot[11],
			lineOneHot[12], lineOneHot[13], lineOneHot[14]:
				dec.isByte = (size == 2'b00);
			default: dec.isByte = 1'b0;
		endcase
	end

	assign dec.isMovep = lineOneHot[0] & ird[8] & eaIsAn;

	// RTR, MOVE to CCR, and the immediate-to-CCR group
	assign dec.toCcr = (lineOneHot[4] & ((ird[11:0] == 12'hE77) | (ird[11:6] == 6'b010011)))
		| (lineOneHot[0] & (opmode == 3'b000));

	assign quick = (ird.generalView.rx == 3'd0) ? 4'd8 : {1'b0, ird.generalView.rx};

	always_comb begin
		ftuConst = '0;
		unique case (1'b1)
			lineOneHot[6], lineOneHot[7]:
				ftuConst = {{(irdPkg::FTU_WIDTH - 8){disp8[7]}}, disp8}; // Bcc.S, MOVEQ
			lineOneHot[5], lineOneHot[14]: ftuConst[3:0] = quick;
			lineOneHot[8], lineOneHot[12]: ftuConst[3:0] = 4'hF; // MUL/DIV loop count
			lineOneHot[4]: ftuConst[7] = 1'b1; // TAS set bit
			default: ;
		endcase
	end
	assign dec.ftuConst = ftuConst;

	always_comb begin
		if (lineOneHot[4]) begin
			case (ird[6:5])
				2'b11: dec.macroTvn = irdPkg::TVN_TRAPV;
				2'b10: dec.macroTvn = irdPkg::TVN_TRAP_BASE + {4'b0000, ird[3:0]}; // TRAP #n
				default: dec.macroTvn = irdPkg::TVN_CHK;
			endcase
		end else begin
			dec.macroTvn = irdPkg::TVN_DIVZERO; // DIVU/DIVS
		end
	end

	// ADDA/SUBA, ADDQ/SUBQ to An, MOVEA
	assign dec.inhibitCcr = ((lineOneHot[9] | lineOneHot[13]) & sizeIs11)
		| (lineOneHot[5] & eaIsAn)
		| ((lineOneHot[2] | lineOneHot[3]) & (opmode == 3'b001));
endmodule

// ==== tStateSequencer.sv ====
`timescale 1ns/1ps

module tStateSequencer (
	input logic clk,
	input logic reset,
	input logic wordAvail,
	output logic [3:0] tPhase, // One-hot, bit 0 is T1
	output logic pop
);
	logic cycleEnd;

	// Idle or last phase, next instruction may start
	assign cycleEnd = (tPhase == 4'b0000) | tPhase[3];

	always_ff @(posedge clk) begin
		if (reset) begin
			tPhase <= 4'b0000;
		end else if (cycleEnd) begin
			tPhase <= wordAvail ? 4'b0001 : 4'b0000; // T1 or stay idle
		end else begin
			tPhase <= tPhase << 1; // T1 to T2 to T3 to T4
		end
	end

	assign pop = tPhase[0]; // Head word leaves on the edge ending T1
endmodule

// ==== prefetchQueue.sv ====
`timescale 1ns/1ps

module prefetchQueue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic wordValid,
	input irdPkg::opcodeWord wordIn,
	input logic pop,
	output irdPkg::opcodeWord headWord,
	output logic wordAvail,
	output logic creditReturn
);
	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(QUEUE_DEPTH - 1);
	localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(QUEUE_DEPTH);

	irdPkg::opcodeWord mem [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] wrPtr;
	logic [PTR_WIDTH-1:0] rdPtr;
	logic [CNT_WIDTH-1:0] count; // Occupancy

	always_ff @(posedge clk) begin
		if (wordValid) begin
			mem[wrPtr] <= wordIn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (wordValid) begin
				wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1; // Wrap for any depth
			end
			if (pop) begin
				rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
			end
			case ({wordValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // Both or neither, count holds
			endcase
			creditReturn <= pop; // Slot freed, credit back next cycle
		end
	end

	assign headWord = mem[rdPtr];
	assign wordAvail = (count != '0);

	// Source spent a credit it never had
	assert property (@(posedge clk) disable iff (reset) wordValid |-> (count != FULL_COUNT))
		else $error("prefetchQueue: push while full");

	// Sequencer started T1 on an empty queue
	assert property (@(posedge clk) disable iff (reset) pop |-> wordAvail)
		else $error("prefetchQueue: pop while empty");
endmodule

// ==== irdDecodeIf.sv ====
`timescale 1ns/1ps

// Decoded execution controls, decoder to stage
interface irdDecodeIf;
	logic [2:0] rx;
	logic [2:0] ry;
	logic rxIsAreg;
	logic ryIsAreg;
	logic rxIsDt; // Rx through data temp
	logic ryIsDt;
	logic rxIsUsp;
	logic rxIsMovem;
	logic movemPreDecr;
	logic implicitSp; // SP used without naming it
	logic isByte;
	logic isPcRel;
	logic isTas;
	logic isMovep;
	logic toCcr;
	logic inhibitCcr;
	logic [irdPkg::FTU_WIDTH-1:0] ftuConst;
	logic [irdPkg::TVN_WIDTH-1:0] macroTvn;

	modport decoder (
		output rx, ry, rxIsAreg, ryIsAreg, rxIsDt, ryIsDt, rxIsUsp, rxIsMovem,
			movemPreDecr, implicitSp, isByte, isPcRel, isTas, isMovep, toCcr,
			inhibitCcr, ftuConst, macroTvn
	);

	modport stage (
		input rx, ry, rxIsAreg, ryIsAreg, rxIsDt, ryIsDt, rxIsUsp, rxIsMovem,
			movemPreDecr, implicitSp, isByte, isPcRel, isTas, isMovep, toCcr,
			inhibitCcr, ftuConst, macroTvn
	);
endinterface

// ==== irdPkg.sv ====
package irdPkg;
	localparam int OPCODE_WIDTH = 16; // One 68000 opcode word
	localparam int FTU_WIDTH = 16; // FTU constant bus
	localparam int TVN_WIDTH = 8; // Trap vector number

	// Group 2 exception vectors
	localparam logic [TVN_WIDTH-1:0] TVN_DIVZERO = 8'd5;
	localparam logic [TVN_WIDTH-1:0] TVN_CHK = 8'd6;
	localparam logic [TVN_WIDTH-1:0] TVN_TRAPV = 8'd7;
	localparam logic [TVN_WIDTH-1:0] TVN_TRAP_BASE = 8'd32; // TRAP #0, plus vector nibble

	// Same opcode word, two field layouts
	typedef union packed {
		struct packed {
			logic [3:0] line; // Bits 15-12
			logic [2:0] rx;
			logic [2:0] opmode; // Bits 8-6, size in the low two
			logic [2:0] eaMode;
			logic [2:0] eaReg;
		} generalView;
		struct packed {
			logic [3:0] line;
			logic [3:0] cond; // Bcc condition or bits 11-8 as one nibble
			logic [7:0] disp8; // Short branch displacement, MOVEQ data
		} branchView;
	} opcodeWord;
endpackage
